/* core_readback.sv */
`include "radio_core_settings.svh"

module core_readback (
   input  logic                     radio_clk,
   input  logic                     bus_rst,
   input  radio_core_pkg::rb_sel_t    i_rb_sel,
   input  radio_core_pkg::status_t    i_gpsdo_st,
   input  radio_core_pkg::set_data_t  i_rb_misc,
   input  radio_core_pkg::lock_t      i_lock_signals,
   input  radio_core_pkg::vita_time_t i_lora_time,
   output radio_core_pkg::rb_data_t   o_rb_data
);

   // two stages on the async lock inputs
   radio_core_pkg::lock_t lock_meta;
   radio_core_pkg::lock_t lock_sync;

   always_ff @(posedge radio_clk) begin
      if (bus_rst) begin
         lock_meta <= '0;
         lock_sync <= '0;
      end else begin
         lock_meta <= i_lock_signals;
         lock_sync <= lock_meta;
      end
   end

   //////////////////////////////////////////////////////////////
   // readback word mux
   //////////////////////////////////////////////////////////////

   // combinational mux on the registered select
   always_comb begin
      case (i_rb_sel)
         // signature and compat
         3'd0: o_rb_data = {`RB_SIGNATURE, `COMPAT_MAJOR, `COMPAT_MINOR};
         // radio count, gpsdo status, board misc inputs
         3'd2: o_rb_data = {16'h0000, `RADIO_STATUS, i_gpsdo_st, i_rb_misc};
         3'd3: o_rb_data = {62'd0, lock_sync};
         // last lora trigger timestamp
         3'd4: o_rb_data = i_lora_time;
         // addresses 1 and 5 to 7 read as zero
         default: o_rb_data = '0;
      endcase
   end

endmodule

/* core_setting_regs.sv */
`include "radio_core_settings.svh"

module core_setting_regs (
   input  logic                    radio_clk,
   input  logic                    bus_rst,
   input  logic                    i_set_stb,
   input  radio_core_pkg::set_addr_t i_set_addr,
   input  radio_core_pkg::set_data_t i_set_data,
   output radio_core_pkg::set_data_t o_misc_outs,
   output radio_core_pkg::rb_sel_t   o_rb_sel,
   output radio_core_pkg::status_t   o_gpsdo_st,
   output logic                    o_time_sync,
   output radio_core_pkg::pps_sel_t  o_pps_select
);

   // address match per register gated by the strobe
   logic wr_misc;
   logic wr_rb_sel;
   logic wr_gpsdo;
   logic wr_sync;

   assign wr_misc   = i_set_stb && (i_set_addr == `SR_CORE_MISC);
   assign wr_rb_sel = i_set_stb && (i_set_addr == `SR_CORE_READBACK);
   assign wr_gpsdo  = i_set_stb && (i_set_addr == `SR_CORE_GPSDO_ST);
   assign wr_sync   = i_set_stb && (i_set_addr == `SR_CORE_SYNC);

   // misc, readback select and sync all clear on reset
   always_ff @(posedge radio_clk) begin
      if (bus_rst) begin
         o_misc_outs  <= '0;
         o_rb_sel     <= '0;
         o_time_sync  <= 1'b0;
         o_pps_select <= '0;
      end else begin
         if (wr_misc)
            o_misc_outs <= i_set_data;
         if (wr_rb_sel)
            o_rb_sel <= i_set_data[2:0];
         // sync word splits into time_sync and pps source
         if (wr_sync) begin
            o_time_sync  <= i_set_data[2];
            o_pps_select <= i_set_data[1:0];
         end
      end
   end

   // gpsdo status keeps its value through bus_rst
   always_ff @(posedge radio_clk) begin
      if (wr_gpsdo)
         o_gpsdo_st <= i_set_data[7:0];
   end

endmodule

/* lora_time_capture.sv */
module lora_time_capture (
   input  logic                     radio_clk,
   input  logic                     bus_rst,
   input  logic                     i_lora_trigger,
   input  radio_core_pkg::vita_time_t i_vita_time,
   output radio_core_pkg::vita_time_t o_lora_time
);

   // trigger sync chain and edge delay
   logic trig_meta;
   logic trig_sync;
   logic trig_dly;
   logic trig_rise;

   always_ff @(posedge radio_clk) begin
      if (bus_rst) begin
         trig_meta <= 1'b0;
         trig_sync <= 1'b0;
         trig_dly  <= 1'b0;
      end else begin
         trig_meta <= i_lora_trigger;
         trig_sync <= trig_meta;
         trig_dly  <= trig_sync;
      end
   end

   assign trig_rise = trig_sync & ~trig_dly;

   // timestamp held until next trigger
   always_ff @(posedge radio_clk) begin
      if (bus_rst)
         o_lora_time <= '0;
      else if (trig_rise)
         o_lora_time <= i_vita_time;
   end

endmodule

/* pps_generator.sv */
`include "radio_core_settings.svh"

module pps_generator (
   input  logic radio_clk,
   input  logic bus_rst,
   output logic o_pps
);

   localparam int CNT_W = $clog2(`PPS_PERIOD_CYCLES);

   // cycle count within one pps period
   logic [CNT_W-1:0] cnt;

   always_ff @(posedge radio_clk) begin
      if (bus_rst) begin
         cnt   <= '0;
         o_pps <= 1'b0;
      end else begin
         // wrap at end of period
         if (cnt == CNT_W'(`PPS_PERIOD_CYCLES - 1))
            cnt <= '0;
         else
            cnt <= cnt + 1'b1;
         // high for the first part of every period
         o_pps <= (cnt < CNT_W'(`PPS_HIGH_CYCLES));
      end
   end

endmodule

/* pps_select_sync.sv */
module pps_select_sync (
   input  logic                   radio_clk,
   input  logic                   bus_rst,
   input  logic                   i_pps_gpsdo,
   input  logic                   i_pps_ext,
   input  logic                   i_pps_int,
   input  radio_core_pkg::pps_sel_t i_pps_select,
   output logic                   o_pps_edge
);

   // sources packed as {int, ext, gpsdo}
   logic [2:0] pps_meta;
   logic [2:0] pps_sync;
   logic       pps_mux;
   logic       pps_dly;

   //////////////////////////////////////////////////////////////
   // two-flop synchronizers, one per source
   //////////////////////////////////////////////////////////////

   always_ff @(posedge radio_clk) begin
      if (bus_rst) begin
         pps_meta <= '0;
         pps_sync <= '0;
      end else begin
         pps_meta <= {i_pps_int, i_pps_ext, i_pps_gpsdo};
         pps_sync <= pps_meta;
      end
   end

   // source select, 3 means no pps at all
   always_comb begin
      case (i_pps_select)
         2'd0:    pps_mux = pps_sync[0];
         2'd1:    pps_mux = pps_sync[1];
         2'd2:    pps_mux = pps_sync[2];
         default: pps_mux = 1'b0;
      endcase
   end

   // delay flop and registered rising edge
   always_ff @(posedge radio_clk) begin
      if (bus_rst) begin
         pps_dly    <= 1'b0;
         o_pps_edge <= 1'b0;
      end else begin
         pps_dly    <= pps_mux;
         o_pps_edge <= pps_mux & ~pps_dly;
      end
   end

endmodule

/* radio_core_ctrl.f */
+incdir+.
radio_core_pkg.sv
core_setting_regs.sv
pps_generator.sv
pps_select_sync.sv
vita_timekeeper.sv
lora_time_capture.sv
core_readback.sv
radio_core_ctrl.sv
tb_radio_core_ctrl.sv

/* radio_core_ctrl.sv */
module radio_core_ctrl (
   input  logic                     radio_clk,
   input  logic                     bus_rst,
   // settings bus
   input  logic                     i_set_stb,
   input  radio_core_pkg::set_addr_t  i_set_addr,
   input  radio_core_pkg::set_data_t  i_set_data,
   // pps inputs
   input  logic                     i_pps_gpsdo,
   input  logic                     i_pps_ext,
   // misc board inputs
   input  radio_core_pkg::lock_t      i_lock_signals,
   input  logic                     i_lora_trigger,
   input  radio_core_pkg::set_data_t  i_rb_misc,
   // outputs
   output radio_core_pkg::set_data_t  o_misc_outs,
   output radio_core_pkg::rb_data_t   o_rb_data,
   output radio_core_pkg::vita_time_t o_vita_time,
   output logic                     o_pps_edge
);

   // register outputs
   radio_core_pkg::rb_sel_t    rb_sel;
   radio_core_pkg::status_t    gpsdo_st;
   radio_core_pkg::pps_sel_t   pps_select;
   logic                     time_sync;
   // timing
   logic                     pps_int;
   radio_core_pkg::vita_time_t lora_time;

   //////////////////////////////////////////////////////////////
   // setting registers
   //////////////////////////////////////////////////////////////

   core_setting_regs setting_regs_i (
      .radio_clk    (radio_clk),
      .bus_rst      (bus_rst),
      .i_set_stb    (i_set_stb),
      .i_set_addr   (i_set_addr),
      .i_set_data   (i_set_data),
      .o_misc_outs  (o_misc_outs),
      .o_rb_sel     (rb_sel),
      .o_gpsdo_st   (gpsdo_st),
      .o_time_sync  (time_sync),
      .o_pps_select (pps_select)
   );

   //////////////////////////////////////////////////////////////
   // pps and vita time
   //////////////////////////////////////////////////////////////

   // internal pps source
   pps_generator pps_gen_i (
      .radio_clk (radio_clk),
      .bus_rst   (bus_rst),
      .o_pps     (pps_int)
   );

   pps_select_sync pps_sel_i (
      .radio_clk    (radio_clk),
      .bus_rst      (bus_rst),
      .i_pps_gpsdo  (i_pps_gpsdo),
      .i_pps_ext    (i_pps_ext),
      .i_pps_int    (pps_int),
      .i_pps_select (pps_select),
      .o_pps_edge   (o_pps_edge)
   );

   vita_timekeeper timekeeper_i (
      .radio_clk   (radio_clk),
      .bus_rst     (bus_rst),
      .i_pps_edge  (o_pps_edge),
      .i_time_sync (time_sync),
      .o_vita_time (o_vita_time)
   );

   // lora trigger timestamp
   lora_time_capture lora_cap_i (
      .radio_clk      (radio_clk),
      .bus_rst        (bus_rst),
      .i_lora_trigger (i_lora_trigger),
      .i_vita_time    (o_vita_time),
      .o_lora_time    (lora_time)
   );

   //////////////////////////////////////////////////////////////
   // readback
   //////////////////////////////////////////////////////////////

   core_readback readback_i (
      .radio_clk      (radio_clk),
      .bus_rst        (bus_rst),
      .i_rb_sel       (rb_sel),
      .i_gpsdo_st     (gpsdo_st),
      .i_rb_misc      (i_rb_misc),
      .i_lock_signals (i_lock_signals),
      .i_lora_time    (lora_time),
      .o_rb_data      (o_rb_data)
   );

endmodule

/* radio_core_pkg.sv */
package radio_core_pkg;

   // settings bus address
   typedef logic [7:0] set_addr_t;

   // settings bus data, also the misc output word
   typedef logic [31:0] set_data_t;

   // readback select
   typedef logic [2:0] rb_sel_t;

   // one readback word
   typedef logic [63:0] rb_data_t;

   // vita time, counts radio_clk cycles
   typedef logic [63:0] vita_time_t;

   // pps source select
   // 0 gpsdo, 1 external, 2 internal, 3 none
   typedef logic [1:0] pps_sel_t;

   // status bytes (gpsdo, radio count)
   typedef logic [7:0] status_t;

   // front-end lock inputs
   typedef logic [1:0] lock_t;

endpackage

/* radio_core_settings.svh */
`ifndef RADIO_CORE_SETTINGS_SVH
`define RADIO_CORE_SETTINGS_SVH

//////////////////////////////////////////////////////////////
// settings bus addresses
//////////////////////////////////////////////////////////////

// misc output word
`define SR_CORE_MISC       8'd16
// readback select, low 3 bits used
`define SR_CORE_READBACK   8'd32
// gpsdo status byte
`define SR_CORE_GPSDO_ST   8'd40
// sync word: bit 2 time_sync, bits 1..0 pps_select
`define SR_CORE_SYNC       8'd48

//////////////////////////////////////////////////////////////
// readback constants
//////////////////////////////////////////////////////////////

// compat numbers, reported in readback word 0
`define COMPAT_MAJOR       16'h000E
`define COMPAT_MINOR       16'h0000
// upper half of readback word 0
`define RB_SIGNATURE       32'hACE0BA5E
// single radio build
`define RADIO_STATUS       8'd1

//////////////////////////////////////////////////////////////
// internal pps generator
//////////////////////////////////////////////////////////////

// period in radio_clk cycles, shortened for simulation
`define PPS_PERIOD_CYCLES  1000
// high time in radio_clk cycles
`define PPS_HIGH_CYCLES    100

`endif

/* tb_radio_core_ctrl.sv */
`include "radio_core_settings.svh"

module tb_radio_core_ctrl;

   timeunit 1ns;
   timeprecision 100ps;

   logic                       radio_clk;
   logic                       bus_rst;
   logic                       i_set_stb;
   radio_core_pkg::set_addr_t  i_set_addr;
   radio_core_pkg::set_data_t  i_set_data;
   logic                       i_pps_gpsdo;
   logic                       i_pps_ext;
   radio_core_pkg::lock_t      i_lock_signals;
   logic                       i_lora_trigger;
   radio_core_pkg::set_data_t  i_rb_misc;
   radio_core_pkg::set_data_t  o_misc_outs;
   radio_core_pkg::rb_data_t   o_rb_data;
   radio_core_pkg::vita_time_t o_vita_time;
   logic                       o_pps_edge;

   // model of what the core should hold
   radio_core_pkg::rb_sel_t    model_sel;
   radio_core_pkg::status_t    model_gpsdo;
   radio_core_pkg::set_data_t  model_misc;
   radio_core_pkg::set_data_t  model_rb_misc;
   radio_core_pkg::lock_t      model_lock;
   radio_core_pkg::vita_time_t model_lora;
   logic                       rb_check_en;
   int                         seed;
   int                         rb_errors;
   int                         check_errors;
   int                         timeouts;

   radio_core_ctrl dut_i (.*);

   initial begin
      radio_clk = 1'b0;
      forever #2 radio_clk = ~radio_clk;
   end

   //////////////////////////////////////////////////////////////
   // reference model and readback compare
   //////////////////////////////////////////////////////////////

   // word layout per readback address
   function automatic radio_core_pkg::rb_data_t rb_expect(
      input radio_core_pkg::rb_sel_t    sel,
      input radio_core_pkg::status_t    gpsdo,
      input radio_core_pkg::set_data_t  misc,
      input radio_core_pkg::lock_t      lock,
      input radio_core_pkg::vita_time_t lora);
      radio_core_pkg::rb_data_t rb;
      rb = '0;
      if (sel == 3'd0) begin
         rb[63:32] = `RB_SIGNATURE;
         rb[31:16] = `COMPAT_MAJOR;
         rb[15:0]  = `COMPAT_MINOR;
      end else if (sel == 3'd2) begin
         rb[47:40] = `RADIO_STATUS;
         rb[39:32] = gpsdo;
         rb[31:0]  = misc;
      end else if (sel == 3'd3) begin
         rb[1:0] = lock;
      end else if (sel == 3'd4) begin
         // lower bound of the capture window
         rb = lora;
      end
      return rb;
   endfunction

   always @(negedge radio_clk) begin
      radio_core_pkg::rb_data_t exp_rb;
      exp_rb = rb_expect(model_sel, model_gpsdo, model_rb_misc, model_lock, model_lora);
      if (rb_check_en && model_sel == 3'd4) begin
         if (o_rb_data < exp_rb || o_rb_data > exp_rb + 64'd4) begin
            $display("FAIL t=%0t o_rb_data exp=%h..+4 got=%h", $time, exp_rb, o_rb_data);
            rb_errors++;
         end
      end else if (rb_check_en && o_rb_data !== exp_rb) begin
         $display("FAIL t=%0t o_rb_data exp=%h got=%h", $time, exp_rb, o_rb_data);
         rb_errors++;
      end
   end

   //////////////////////////////////////////////////////////////
   // bus and wait helpers
   //////////////////////////////////////////////////////////////

   task automatic set_write(input radio_core_pkg::set_addr_t addr,
                            input radio_core_pkg::set_data_t data);
      @(posedge radio_clk);
      i_set_stb  <= 1'b1;
      i_set_addr <= addr;
      i_set_data <= data;
      @(posedge radio_clk);
      i_set_stb  <= 1'b0;
   endtask

   // register loads on the strobe edge and the mux follows
   task automatic select_rb(input radio_core_pkg::rb_sel_t sel);
      rb_check_en = 1'b0;
      set_write(`SR_CORE_READBACK, {29'd0, sel});
      model_sel   = sel;
      rb_check_en = 1'b1;
      @(negedge radio_clk);
   endtask

   task automatic check_misc();
      @(negedge radio_clk);
      if (o_misc_outs !== model_misc) begin
         $display("FAIL t=%0t o_misc_outs exp=%h got=%h", $time, model_misc, o_misc_outs);
         check_errors++;
      end
   endtask

   task automatic wait_pps_edge(input int limit, output int cycles, output bit seen);
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < limit) begin
         @(negedge radio_clk);
         cycles++;
         if (o_pps_edge)
            seen = 1'b1;
      end
   endtask

   task automatic capture_lora();
      radio_core_pkg::vita_time_t t_trig;
      rb_check_en = 1'b0;
      @(negedge radio_clk);
      t_trig = o_vita_time;
      @(posedge radio_clk);
      i_lora_trigger <= 1'b1;
      // hold past the sync chain and the latch
      repeat (6) @(posedge radio_clk);
      i_lora_trigger <= 1'b0;
      model_lora  = t_trig;
      rb_check_en = 1'b1;
      repeat (3) @(negedge radio_clk);
   endtask

   //////////////////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////////////////

   initial begin
      radio_core_pkg::vita_time_t prev_time;
      radio_core_pkg::set_addr_t  addr;
      logic [31:0] rnd;
      int  cycles;
      bit  seen;
      seed = 32'h31b1f8b1;
      rb_errors = 0;
      check_errors = 0;
      timeouts = 0;
      rb_check_en = 1'b0;
      model_sel = '0;
      model_gpsdo = '0;
      model_misc = '0;
      model_rb_misc = '0;
      model_lock = '0;
      model_lora = '0;
      bus_rst <= 1'b1;
      i_set_stb <= 1'b0;
      i_set_addr <= '0;
      i_set_data <= '0;
      i_pps_gpsdo <= 1'b0;
      i_pps_ext <= 1'b0;
      i_lock_signals <= '0;
      i_lora_trigger <= 1'b0;
      i_rb_misc <= '0;
      repeat (5) @(posedge radio_clk);
      bus_rst <= 1'b0;

      // address 0 is selected after reset
      rb_check_en = 1'b1;
      check_misc();
      prev_time = o_vita_time;
      repeat (20) begin
         @(negedge radio_clk);
         if (o_vita_time !== prev_time + 64'd1) begin
            $display("FAIL t=%0t o_vita_time exp=%h got=%h", $time, prev_time + 64'd1,
                     o_vita_time);
            check_errors++;
         end
         if (o_pps_edge !== 1'b0) begin
            $display("FAIL t=%0t o_pps_edge exp=0 got=%b", $time, o_pps_edge);
            check_errors++;
         end
         prev_time = o_vita_time;
      end

      // load gpsdo status before reading word 2
      rnd = $random(seed);
      set_write(`SR_CORE_GPSDO_ST, rnd);
      model_gpsdo = rnd[7:0];
      select_rb(3'd2);
      repeat (24) begin
         rnd = $random(seed);
         case (rnd[1:0])
            2'd0: begin
               rnd = $random(seed);
               set_write(`SR_CORE_MISC, rnd);
               model_misc = rnd;
            end
            2'd1: begin
               rnd = $random(seed);
               set_write(`SR_CORE_GPSDO_ST, rnd);
               model_gpsdo = rnd[7:0];
            end
            default: begin
               rnd = $random(seed);
               addr = rnd[7:0];
               if (addr == `SR_CORE_MISC || addr == `SR_CORE_READBACK ||
                   addr == `SR_CORE_GPSDO_ST || addr == `SR_CORE_SYNC)
                  addr = 8'hFF;
               set_write(addr, $random(seed));
            end
         endcase
         rnd = $random(seed);
         @(posedge radio_clk);
         i_rb_misc <= rnd;
         model_rb_misc = rnd;
         check_misc();
      end
      select_rb(3'd1);
      select_rb(3'd5);
      select_rb(3'd6);
      select_rb(3'd7);

      // lock inputs through the two stage delay
      select_rb(3'd3);
      repeat (4) begin
         rnd = $random(seed);
         rb_check_en = 1'b0;
         @(posedge radio_clk);
         i_lock_signals <= rnd[1:0];
         model_lock = rnd[1:0];
         cycles = 0;
         @(negedge radio_clk);
         while (o_rb_data !== rb_expect(3'd3, model_gpsdo, model_rb_misc, model_lock,
                                        model_lora) && cycles < 10) begin
            @(negedge radio_clk);
            cycles++;
         end
         if (cycles >= 10) begin
            $display("lock readback never reached %b", model_lock);
            timeouts++;
         end
         rb_check_en = 1'b1;
         repeat (3) @(negedge radio_clk);
      end

      // external pps with time sync armed
      set_write(`SR_CORE_SYNC, 32'h5);
      @(posedge radio_clk);
      i_pps_ext <= 1'b1;
      wait_pps_edge(20, cycles, seen);
      if (!seen) begin
         $display("no pps edge from external source");
         timeouts++;
      end
      @(negedge radio_clk);
      if (seen && o_vita_time >= 64'd10) begin
         $display("FAIL t=%0t o_vita_time exp=<10 got=%0d", $time, o_vita_time);
         check_errors++;
      end
      @(posedge radio_clk);
      i_pps_ext <= 1'b0;

      // no source selected
      set_write(`SR_CORE_SYNC, 32'h7);
      @(posedge radio_clk);
      i_pps_ext   <= 1'b1;
      i_pps_gpsdo <= 1'b1;
      wait_pps_edge(20, cycles, seen);
      if (seen) begin
         $display("FAIL t=%0t o_pps_edge exp=0 got=1", $time);
         check_errors++;
      end
      @(posedge radio_clk);
      i_pps_ext   <= 1'b0;
      i_pps_gpsdo <= 1'b0;
      repeat (4) @(posedge radio_clk);

      // gpsdo source
      set_write(`SR_CORE_SYNC, 32'h4);
      @(posedge radio_clk);
      i_pps_gpsdo <= 1'b1;
      wait_pps_edge(20, cycles, seen);
      if (!seen) begin
         $display("no pps edge from gpsdo source");
         timeouts++;
      end
      @(posedge radio_clk);
      i_pps_gpsdo <= 1'b0;

      // internal pps where the first edge may come from the switch itself
      set_write(`SR_CORE_SYNC, 32'h6);
      wait_pps_edge(2 * `PPS_PERIOD_CYCLES + 10, cycles, seen);
      wait_pps_edge(2 * `PPS_PERIOD_CYCLES + 10, cycles, seen);
      repeat (2) begin
         wait_pps_edge(`PPS_PERIOD_CYCLES + 10, cycles, seen);
         if (!seen) begin
            $display("internal pps edge missing");
            timeouts++;
         end else if (cycles != `PPS_PERIOD_CYCLES) begin
            $display("FAIL t=%0t o_pps_edge period exp=%0d got=%0d", $time,
                     `PPS_PERIOD_CYCLES, cycles);
            check_errors++;
         end
      end

      // lora capture with pps off so time runs straight
      set_write(`SR_CORE_SYNC, 32'h3);
      select_rb(3'd4);
      capture_lora();
      repeat (10 + ($random(seed) & 31)) @(posedge radio_clk);
      capture_lora();

      $display("errors: %0d readback, %0d checks, %0d timeouts", rb_errors,
               check_errors, timeouts);
      if (rb_errors == 0 && check_errors == 0 && timeouts == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

/* vita_timekeeper.sv */
module vita_timekeeper (
   input  logic                     radio_clk,
   input  logic                     bus_rst,
   input  logic                     i_pps_edge,
   input  logic                     i_time_sync,
   output radio_core_pkg::vita_time_t o_vita_time
);

   // zero only when host has armed time sync
   logic zero_now;

   assign zero_now = i_pps_edge && i_time_sync;

   // free-running cycle count
   // realigns to pps while sync bit set
   always_ff @(posedge radio_clk) begin
      if (bus_rst)
         o_vita_time <= '0;
      else if (zero_now)
         o_vita_time <= '0;
      else
         o_vita_time <= o_vita_time + 64'd1;
   end

endmodule
